// File: design/sprite_pkg.sv
// sprite line renderer shared widths, attribute record and default sprite count

package sprite_pkg;

    // **************************************************************************
    // field widths
    // **************************************************************************

    localparam int COLOR_W   = 4;   // vdp palette index
    localparam int HPOS_W    = 9;   // horizontal position in vdp pixels
    localparam int PATTERN_W = 16;  // one sprite row, 8-wide rows leave the low byte zero

    // number of sprite engines when the top level is not told otherwise
    localparam int NUM_SPRITES_DEFAULT = 4;

    // **************************************************************************
    // types
    // **************************************************************************

    // palette index of one pixel, zero is transparent
    typedef logic [COLOR_W-1:0] color_t;

    // counted in vdp pixels from the left edge of the line
    typedef logic [HPOS_W-1:0] hpos_t;

    // row bits, the msb is the leftmost pixel on screen
    typedef logic [PATTERN_W-1:0] pattern_t;

    // everything one engine needs to draw its row on the coming line
    // the fields pack msb first, 16 + 9 + 4 = 29 bits in total
    typedef struct packed {
        pattern_t pattern;   // row bits shown msb first
        hpos_t    hpos;      // vdp pixels to skip after column zero
        color_t   fg_color;  // color of the set pattern bits
    } sprite_attr_t;

endpackage

// File: design/sprite.sv
// sprite engine that holds one sprite row and shifts it out at its horizontal position
`timescale 1ns/10ps

module sprite import sprite_pkg::*; (
    input  logic         reset,          // synchronous, active high
    input  logic         pxclk,          // vga pixel clock, two periods per vdp pixel
    input  logic         vdp_col0_tick,  // the next cycle is vdp column zero
    input  logic         load_tick,      // take a new row and stop rendering the old one
    input  logic         mag,            // magnified sprites, sampled on load_tick
    input  sprite_attr_t attr,           // pattern, position and color of this row
    output color_t       color_out,      // foreground color while visible, else zero
    output logic         visible         // a pattern bit is on screen this cycle
);

    // **************************************************************************
    // state
    // **************************************************************************

    logic       active_reg, active_next;    // rendering between column zero and the next load
    logic [1:0] phase_reg, phase_next;      // pxclk count since column zero, wraps every 4
    logic       mag_reg, mag_next;          // pixels are two vdp pixels wide
    hpos_t      hpos_reg, hpos_next;        // vdp pixels still to skip before the row starts
    logic       parity_reg, parity_next;    // lsb of the loaded hpos
    pattern_t   pattern_reg, pattern_next;  // remaining row bits, msb is on screen
    color_t     fg_color_reg, fg_color_next;

    // the engine comes out of reset idle and waits for column zero
    always_ff @(posedge pxclk) begin
        if (reset) begin
            active_reg <= 1'b0;
            phase_reg  <= 2'd0;
        end else begin
            active_reg <= active_next;
            phase_reg  <= phase_next;
        end
    end

    // the row payload changes on load_tick and while the row shifts out
    always_ff @(posedge pxclk) begin
        mag_reg      <= mag_next;
        hpos_reg     <= hpos_next;
        parity_reg   <= parity_next;
        pattern_reg  <= pattern_next;
        fg_color_reg <= fg_color_next;
    end

    // **************************************************************************
    // next state
    // **************************************************************************

    always_comb begin
        active_next   = active_reg;
        phase_next    = phase_reg + 2'd1;   // free running, only column zero resyncs it
        mag_next      = mag_reg;
        hpos_next     = hpos_reg;
        parity_next   = parity_reg;
        pattern_next  = pattern_reg;
        fg_color_next = fg_color_reg;

        if (load_tick) begin
            active_next   = 1'b0;                 // idle until the line starts
            mag_next      = mag;
            hpos_next     = attr.hpos;
            parity_next   = attr.hpos[0];         // decides which phase a big pixel ends on
            pattern_next  = attr.pattern;
            fg_color_next = attr.fg_color;
        end else if (active_reg && phase_reg[0]) begin
            // an odd phase closes one vdp pixel
            if (hpos_reg != '0) begin
                hpos_next = hpos_reg - hpos_t'(1);  // still left of the sprite
            end else if (!mag_reg || (phase_reg[1] == !parity_reg)) begin
                // magnified pixels end on every other odd phase, and an odd hpos
                // puts that boundary two cycles later in the 4-cycle phase count
                pattern_next = {pattern_reg[PATTERN_W-2:0], 1'b0};
            end
        end

        if (vdp_col0_tick) begin
            active_next = 1'b1;   // p = 0 is the next cycle
            phase_next  = 2'd0;
        end
    end

    // **************************************************************************
    // pixel output
    // **************************************************************************

    // after sixteen shifts the pattern is all zero, so the row ends by itself
    // and nothing shows again until a new row is loaded
    assign visible   = active_reg && (hpos_reg == '0) && pattern_reg[PATTERN_W-1];
    assign color_out = visible ? fg_color_reg : '0;

endmodule

// File: design/sprite_priority.sv
// sprite priority stage that picks the winning color per pixel and flags sprite overlap
`timescale 1ns/10ps

module sprite_priority import sprite_pkg::*; #(
    parameter int NUM_SPRITES = NUM_SPRITES_DEFAULT  // engines feeding this stage
) (
    input  logic                   reset,        // synchronous, active high
    input  logic                   pxclk,        // vga pixel clock
    input  color_t [NUM_SPRITES-1:0] colors,     // per engine color, zero when not showing
    input  logic [NUM_SPRITES-1:0] visible,      // per engine pattern bit on screen
    input  logic                   coinc_clear,  // status read, drop the overlap flag
    output color_t                 color_out,    // merged sprite pixel, zero is transparent
    output logic                   coinc         // sticky, two sprites met on some cycle
);

    localparam int CNT_W = $clog2(NUM_SPRITES + 1);  // wide enough to count every engine

    logic [CNT_W-1:0] num_visible;  // engines showing a bit this cycle
    logic             overlap;      // two or more at once

    // **************************************************************************
    // color merge
    // **************************************************************************

    // the lowest numbered sprite wins, but a color zero sprite is see-through
    // and lets the next one in line show
    always_comb begin : pick_color
        logic found;
        found     = 1'b0;
        color_out = '0;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            if (!found && (colors[i] != '0)) begin
                color_out = colors[i];
                found     = 1'b1;
            end
        end
    end

    // **************************************************************************
    // coincidence
    // **************************************************************************

    // overlap looks at the pattern bits only, color plays no part here
    always_comb begin : count_visible
        num_visible = '0;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            num_visible = num_visible + CNT_W'(visible[i]);
        end
    end

    assign overlap = (num_visible > CNT_W'(1));

    always_ff @(posedge pxclk) begin
        if (reset) begin
            coinc <= 1'b0;
        end else if (overlap) begin
            coinc <= 1'b1;           // a new overlap beats a clear on the same cycle
        end else if (coinc_clear) begin
            coinc <= 1'b0;
        end
    end

endmodule

// File: design/sprite_line.sv
// sprite line renderer top level with the sprite engines and their priority merge
`timescale 1ns/10ps

module sprite_line import sprite_pkg::*; #(
    parameter int NUM_SPRITES = NUM_SPRITES_DEFAULT  // engines on this line
) (
    input  logic                         reset,          // synchronous, active high
    input  logic                         pxclk,          // vga pixel clock, 2x the vdp clock
    input  logic                         load_tick,      // every engine takes its new row
    input  logic                         mag,            // magnified sprites for the coming line
    input  sprite_attr_t [NUM_SPRITES-1:0] attrs,        // one row record per engine
    input  logic                         vdp_col0_tick,  // the next cycle is vdp column zero
    input  logic                         coinc_clear,    // clear the overlap status
    output color_t                       color_out,      // merged sprite pixel
    output logic                         coinc           // sticky sprite overlap status
);

    // **************************************************************************
    // per engine outputs into the priority stage
    // **************************************************************************

    color_t [NUM_SPRITES-1:0] sprite_colors;   // zero where the engine shows nothing
    logic   [NUM_SPRITES-1:0] sprite_visible;  // pattern bit on screen, color ignored

    // all engines share the strobes and mag, each gets its own row record
    for (genvar g = 0; g < NUM_SPRITES; g++) begin : g_sprite
        sprite u_sprite (
            .reset         (reset),
            .pxclk         (pxclk),
            .vdp_col0_tick (vdp_col0_tick),
            .load_tick     (load_tick),
            .mag           (mag),
            .attr          (attrs[g]),
            .color_out     (sprite_colors[g]),
            .visible       (sprite_visible[g])
        );
    end

    // **************************************************************************
    // merge
    // **************************************************************************

    // index 0 has the highest priority, as on the real chip
    sprite_priority #(
        .NUM_SPRITES (NUM_SPRITES)
    ) u_sprite_priority (
        .reset       (reset),
        .pxclk       (pxclk),
        .colors      (sprite_colors),
        .visible     (sprite_visible),
        .coinc_clear (coinc_clear),
        .color_out   (color_out),
        .coinc       (coinc)
    );

endmodule

// File: verification/tb_clock.sv
// testbench clock and reset source, 20 ns pixel clock and a three cycle reset
`timescale 1ns/10ps

module tb_clock (
    output logic pxclk,  // vga pixel clock
    output logic reset   // synchronous, active high
);

    localparam int RESET_CYCLES = 3;  // rising edges that see reset high

    initial begin
        pxclk = 1'b0;
        forever #10 pxclk = ~pxclk;   // half of the 20 ns period
    end

    // released on a falling edge like every other input of the dut
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge pxclk);
        @(negedge pxclk);
        reset = 1'b0;
    end

endmodule

// File: verification/sprite_line_checker.sv
// checker that compares the sprite line outputs with the expected values of each probe
`timescale 1ns/10ps

module sprite_line_checker import sprite_pkg::*; (
    input  logic   pxclk,           // vga pixel clock
    input  logic   reset,           // synchronous, active high
    input  color_t color_out,       // merged pixel from the dut
    input  logic   coinc,           // overlap flag from the dut
    input  logic   check_color,     // compare color_out on the coming rising edge
    input  color_t exp_color,       // expected pixel for that cycle
    input  logic   check_coinc,     // compare coinc on the coming rising edge
    input  logic   exp_coinc,       // expected overlap flag
    output int     mismatch_count,  // wrong values seen so far
    output int     check_count      // compares done so far
);

    // the rising edge still sees the outputs of the cycle that is ending,
    // and the strobes were set up on the falling edge before it
    always @(posedge pxclk) begin
        if (reset) begin
            mismatch_count = 0;
            check_count    = 0;
        end else begin
            if (check_color) begin
                check_count++;
                if (color_out !== exp_color) begin
                    $display("CHECK FAILED time %0t: color_out is %h, expected %h",
                             $time, color_out, exp_color);
                    mismatch_count++;
                end
            end
            if (check_coinc) begin
                check_count++;   // end of line status
                if (coinc !== exp_coinc) begin
                    $display("CHECK FAILED time %0t: coinc is %b, expected %b",
                             $time, coinc, exp_coinc);
                    mismatch_count++;
                end
            end
        end
    end

endmodule

// File: verification/sprite_line_properties.sv
// reset and overlap flag assertions for the sprite line renderer
`timescale 1ns/10ps

module sprite_line_properties import sprite_pkg::*; #(
    parameter int NUM_SPRITES = NUM_SPRITES_DEFAULT  // engines in the bound instance
) (
    input logic                   pxclk,        // vga pixel clock
    input logic                   reset,        // synchronous, active high
    input logic [NUM_SPRITES-1:0] visible,      // pattern bits on screen per engine
    input logic                   coinc_clear,  // status clear strobe
    input color_t                 color_out,    // merged pixel
    input logic                   coinc         // sticky overlap flag
);

    int assert_failures = 0;  // assertions that have failed so far

    // a reset edge leaves every engine idle, so nothing shows right after it
    assert property (@(posedge pxclk) $past(reset) |-> (color_out == '0))
        else begin
            $error("color_out is not zero in the cycle after a reset edge");
            assert_failures++;
        end

    assert property (@(posedge pxclk) disable iff (reset)
        $rose(coinc) |-> $past($countones(visible) > 1))
        else begin
            $error("coinc rose without two visible sprites one cycle before");
            assert_failures++;
        end

    // only a clear strobe or a reset edge may take the flag down
    assert property (@(posedge pxclk) disable iff (reset)
        $fell(coinc) |-> ($past(coinc_clear) || $past(reset)))
        else begin
            $error("coinc fell without a coinc_clear one cycle before");
            assert_failures++;
        end

endmodule

bind sprite_line sprite_line_properties #(
    .NUM_SPRITES (NUM_SPRITES)
) u_sprite_line_properties (
    .pxclk       (pxclk),
    .reset       (reset),
    .visible     (sprite_visible),
    .coinc_clear (coinc_clear),
    .color_out   (color_out),
    .coinc       (coinc)
);

// File: verification/sprite_line_tb.sv
// testbench top for the sprite line renderer, replays scan lines read from a trace file
`timescale 1ns/10ps

module sprite_line_tb import sprite_pkg::*; ();

    localparam int NUM_SPRITES     = NUM_SPRITES_DEFAULT;
    localparam int LINE_CYCLES     = 700;  // cycles watched after column zero
    localparam int CYCLES_PER_LINE = 720;  // timeout budget for one scan line

    logic                           pxclk, reset;
    logic                           load_tick, mag, vdp_col0_tick, coinc_clear;
    sprite_attr_t [NUM_SPRITES-1:0] attrs;
    color_t                         color_out;
    logic                           coinc;

    logic   check_color, check_coinc, exp_coinc;  // strobes into the checker
    color_t exp_color;
    int     mismatch_count, check_count;

    // one entry per scan line, probes in file order
    sprite_attr_t [NUM_SPRITES-1:0] line_attrs [$];
    logic   line_mag [$], line_clear [$], line_coinc [$];
    int     probe_line [$], probe_p [$];
    color_t probe_color [$];

    int trace_errors = 0;
    int hang_count   = 0;
    int cycle_count  = 0;
    int cycle_limit  = 1000000;  // shrunk to fit the trace once it is read
    int next_probe   = 0;        // first probe not yet handed to the checker

    tb_clock u_tb_clock (.pxclk(pxclk), .reset(reset));

    sprite_line #(
        .NUM_SPRITES (NUM_SPRITES)
    ) u_sprite_line (
        .reset         (reset),
        .pxclk         (pxclk),
        .load_tick     (load_tick),
        .mag           (mag),
        .attrs         (attrs),
        .vdp_col0_tick (vdp_col0_tick),
        .coinc_clear   (coinc_clear),
        .color_out     (color_out),
        .coinc         (coinc)
    );

    sprite_line_checker u_sprite_line_checker (
        .pxclk          (pxclk),
        .reset          (reset),
        .color_out      (color_out),
        .coinc          (coinc),
        .check_color    (check_color),
        .exp_color      (exp_color),
        .check_coinc    (check_coinc),
        .exp_coinc      (exp_coinc),
        .mismatch_count (mismatch_count),
        .check_count    (check_count)
    );

    // **************************************************************************
    // trace reading
    // **************************************************************************

    task automatic read_trace();
        int    fd;
        string text;
        int    pat [NUM_SPRITES];
        int    hp [NUM_SPRITES];
        int    col [NUM_SPRITES];
        int    mag_val, clear_val, p_val, c_val;
        sprite_attr_t [NUM_SPRITES-1:0] set;
        fd = $fopen("verification/sprite_line_trace.txt", "r");
        if (fd == 0) begin
            $display("the trace file could not be opened");
            trace_errors++;
            return;
        end
        while ($fgets(text, fd) != 0) begin
            if (text.len() < 2 || text[0] == "#") continue;   // blank or comment
            if (text[0] == "L" && $sscanf(text, "L %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    pat[0], hp[0], col[0], pat[1], hp[1], col[1], pat[2], hp[2], col[2],
                    pat[3], hp[3], col[3], mag_val, clear_val) == 14) begin
                for (int s = 0; s < NUM_SPRITES; s++) begin
                    set[s] = '{pattern: pattern_t'(pat[s]), hpos: hpos_t'(hp[s]),
                               fg_color: color_t'(col[s])};
                end
                line_attrs.push_back(set);
                line_mag.push_back(mag_val[0]);
                line_clear.push_back(clear_val[0]);
                line_coinc.push_back(1'b0);   // the E record fills this in
            end else if (text[0] == "P" && line_attrs.size() > 0
                         && $sscanf(text, "P %d %h", p_val, c_val) == 2) begin
                probe_line.push_back(line_attrs.size() - 1);
                probe_p.push_back(p_val);
                probe_color.push_back(color_t'(c_val));
            end else if (text[0] == "E" && line_attrs.size() > 0
                         && $sscanf(text, "E %d", c_val) == 1) begin
                line_coinc[line_coinc.size() - 1] = c_val[0];
            end else begin
                $display("unreadable trace record: %s", text);
                trace_errors++;
            end
        end
        $fclose(fd);
        if (line_attrs.size() == 0) begin
            $display("the trace file holds no scan lines");
            trace_errors++;
        end
    endtask

    // **************************************************************************
    // one scan line, all inputs change on falling edges
    // **************************************************************************

    task automatic run_line(input int n);
        @(negedge pxclk);
        load_tick = 1'b1;
        attrs     = line_attrs[n];
        mag       = line_mag[n];
        @(negedge pxclk);
        load_tick = 1'b0;
        @(negedge pxclk);
        vdp_col0_tick = 1'b1;   // two cycles after the load
        for (int p = 0; p < LINE_CYCLES; p++) begin
            @(negedge pxclk);   // the middle of cycle p
            vdp_col0_tick = 1'b0;
            if (next_probe < probe_p.size() && probe_line[next_probe] == n
                && probe_p[next_probe] == p) begin
                check_color = 1'b1;
                exp_color   = probe_color[next_probe];
                next_probe++;
            end else begin
                check_color = 1'b0;
            end
        end
        @(negedge pxclk);
        check_color = 1'b0;
        check_coinc = 1'b1;
        exp_coinc   = line_coinc[n];
        @(negedge pxclk);
        check_coinc = 1'b0;
        coinc_clear = line_clear[n];   // the status read of a real host
        @(negedge pxclk);
        coinc_clear = 1'b0;
        // a probe left over here was out of order or past the end of the line
        while (next_probe < probe_p.size() && probe_line[next_probe] == n) begin
            $display("probe at p = %0d of line %0d was never reached",
                     probe_p[next_probe], n);
            trace_errors++;
            next_probe++;
        end
    endtask

    task automatic finish_run();
        int total;
        int assert_count;
        assert_count = u_sprite_line.u_sprite_line_properties.assert_failures;
        total = mismatch_count + trace_errors + hang_count + assert_count;
        $display("checks %0d, mismatches %0d, assertion failures %0d, trace errors %0d, hangs %0d",
                 check_count, mismatch_count, assert_count, trace_errors, hang_count);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        load_tick     = 1'b0;
        mag           = 1'b0;
        attrs         = '0;
        vdp_col0_tick = 1'b0;
        coinc_clear   = 1'b0;
        check_color   = 1'b0;
        check_coinc   = 1'b0;
        exp_color     = '0;
        exp_coinc     = 1'b0;
        read_trace();
        cycle_limit = line_attrs.size() * CYCLES_PER_LINE + 100;
        wait (reset === 1'b0);
        if (trace_errors == 0) begin
            for (int n = 0; n < line_attrs.size(); n++) begin
                run_line(n);
            end
        end
        @(negedge pxclk);
        finish_run();
    end

    // counts every clock from time zero, reset included
    always @(posedge pxclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("the run hung, no end of test after %0d cycles", cycle_count);
            hang_count = 1;
            finish_run();
        end
    end

endmodule

// File: verification/sprite_line_trace.txt
# L: pattern hpos color (hex) for sprites 0 to 3, then mag and the coinc clear flag
# P: cycle p after column zero (decimal) and the expected color_out (hex)
# E: expected coinc at the end of the line
L c003 000 5  0000 000 0  0000 000 0  0000 000 0  0 0
P 0 5
P 4 0
P 31 5
P 32 0
E 0
L 8001 001 7  0000 000 0  0000 000 0  0000 000 0  0 0
P 1 0
P 2 7
P 33 7
P 34 0
E 0
L 8000 000 3  0000 000 0  ffff 064 a  0000 000 0  0 0
P 0 3
P 199 0
P 200 a
P 232 0
E 0
L 0000 000 0  8001 00a 6  0000 000 0  0000 000 0  1 0
P 20 6
P 24 0
P 83 6
P 84 0
E 0
L 0000 000 0  0000 000 0  0000 000 0  c001 007 9  1 0
P 13 0
P 21 9
P 77 9
P 78 0
E 0
L 0000 000 0  ff00 014 4  0000 000 0  ffff 010 c  0 0
P 35 c
P 40 4
P 56 c
P 64 0
E 1
L ffff 032 0  0000 000 0  ffff 032 2  0000 000 0  0 1
P 100 2
P 132 0
E 1
L f000 000 1  f000 028 8  0000 000 0  0000 000 0  0 0
P 7 1
P 80 8
E 0
L 0000 00a f  8000 0ff b  0000 000 0  0000 000 0  0 0
P 20 0
P 510 b
P 512 0
E 0

// File: all.f
design/sprite_pkg.sv
design/sprite.sv
design/sprite_priority.sv
design/sprite_line.sv
verification/tb_clock.sv
verification/sprite_line_checker.sv
verification/sprite_line_properties.sv
verification/sprite_line_tb.sv

// File: Bender.yml
package:
  name: sprite_line

sources:
  - files:
      - design/sprite_pkg.sv
      - design/sprite.sv
      - design/sprite_priority.sv
      - design/sprite_line.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/sprite_line_checker.sv
      - verification/sprite_line_properties.sv
      - verification/sprite_line_tb.sv
